// ==== common/sensor_defines.svh ====
`ifndef SENSOR_DEFINES_SVH
`define SENSOR_DEFINES_SVH

// array geometry.
`define ARRAY_ROWS 8
`define ARRAY_COLS 24
`define PIXEL_BITS 8

// output bus, one row leaves as BEATS_PER_ROW beats of BUS_PIXELS pixels.
`define BUS_PIXELS 8
`define BEATS_PER_ROW 3

// phase lengths in clk cycles.
`define ERASE_CYCLES 5
`define EXPOSE_CYCLES 64
`define CONVERT_CYCLES 256 // one ramp step per cycle.
`define ROW_CYCLES 8 // one read slot per row.

`endif

// ==== common/sensor_pkg.sv ====
`default_nettype none

`include "sensor_defines.svh"

package sensor_pkg;

	typedef logic [`PIXEL_BITS-1:0] pixel_code_t;
	typedef logic [`ARRAY_ROWS-1:0] row_sel_t; // one-hot.
	typedef logic [`ARRAY_COLS*`PIXEL_BITS-1:0] row_bus_t;
	typedef logic [`BUS_PIXELS*`PIXEL_BITS-1:0] beat_t; // pixel n in byte n.

	typedef enum logic [1:0] {
		phase_erase,
		phase_expose,
		phase_convert,
		phase_read
	} phase_t;

	// broadcast to every cell.
	typedef struct packed {
		logic erase;
		logic ramp_step; // high on each convert cycle.
		pixel_code_t ramp_code; // gray coded.
	} pixel_ctrl_t;

	// synthetic scene seen by the array.
	function automatic pixel_code_t scene_level(input int row, input int col);
		return pixel_code_t'((row * 29 + col * 11 + 40) % 256);
	endfunction

endpackage

`default_nettype wire

// ==== design/frame_sequencer.sv ====
`default_nettype none

`include "sensor_defines.svh"

module frame_sequencer (
	input  logic                    clk,
	input  logic                    reset,
	output sensor_pkg::pixel_ctrl_t pixel_ctrl,
	output sensor_pkg::row_sel_t    row_sel,
	output logic                    new_row,
	output logic                    frame_done
);
	import sensor_pkg::*;

	localparam int count_bits = $clog2(`CONVERT_CYCLES);
	localparam int row_bits = $clog2(`ARRAY_ROWS + 1);

	// phase, count and row_index describe the cycle that the outputs show next.
	phase_t phase;
	logic [count_bits-1:0] count; // cycle in phase, or in row slot during read.
	logic [row_bits-1:0] row_index; // reaches ARRAY_ROWS on the frame done step.

	pixel_ctrl_t ctrl_next;
	row_sel_t row_sel_next;
	logic new_row_next;
	logic frame_done_next;
	logic done_step;

	assign done_step = (row_index == row_bits'(`ARRAY_ROWS));

	always_comb begin
		ctrl_next = '0;
		row_sel_next = '0;
		new_row_next = 1'b0;
		frame_done_next = 1'b0;
		case (phase)
			phase_erase: ctrl_next.erase = 1'b1;
			phase_convert: begin
				ctrl_next.ramp_step = 1'b1;
				ctrl_next.ramp_code = pixel_code_t'(count ^ (count >> 1)); // binary to gray.
			end
			phase_read: begin
				if (done_step) begin
					frame_done_next = 1'b1;
				end else begin
					row_sel_next = row_sel_t'(1) << row_index;
					new_row_next = (count == '0);
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			phase <= phase_erase;
			count <= '0;
			row_index <= '0;
			pixel_ctrl <= '0;
			row_sel <= '0;
			new_row <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			pixel_ctrl <= ctrl_next;
			row_sel <= row_sel_next;
			new_row <= new_row_next;
			frame_done <= frame_done_next;
			count <= count + 1'b1;
			case (phase)
				phase_erase:
					if (count == count_bits'(`ERASE_CYCLES - 1)) begin
						phase <= phase_expose;
						count <= '0;
					end
				phase_expose:
					if (count == count_bits'(`EXPOSE_CYCLES - 1)) begin
						phase <= phase_convert;
						count <= '0;
					end
				phase_convert:
					if (count == count_bits'(`CONVERT_CYCLES - 1)) begin
						phase <= phase_read;
						count <= '0;
						row_index <= '0;
					end
				phase_read:
					if (done_step) begin
						phase <= phase_erase; // next frame right away.
						count <= '0;
						row_index <= '0;
					end else if (count == count_bits'(`ROW_CYCLES - 1)) begin
						count <= '0;
						row_index <= row_index + 1'b1;
					end
				default: phase <= phase_erase;
			endcase
		end
	end

	// never more than one row drives the row bus, and a row holds for its whole slot.
	row_sel_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(row_sel) && (new_row || row_sel == '0 || $stable(row_sel)));

endmodule

`default_nettype wire

// ==== pixel_array/pixel_cell.sv ====
`default_nettype none

`include "sensor_defines.svh"

module pixel_cell #(
	parameter int row_index = 0,
	parameter int col_index = 0
) (
	input  logic                    clk,
	input  logic                    reset,
	input  sensor_pkg::pixel_ctrl_t pixel_ctrl,
	output sensor_pkg::pixel_code_t code
);
	import sensor_pkg::*;

	// brighter pixels trip the comparator earlier.
	localparam pixel_code_t threshold =
		pixel_code_t'((2 ** `PIXEL_BITS) - 1 - scene_level(row_index, col_index));

	pixel_code_t count; // ramp steps seen since erase.
	logic hit; // comparator has fired.

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count <= '0;
			hit <= 1'b0;
		end else if (pixel_ctrl.erase) begin
			count <= '0;
			hit <= 1'b0;
		end else if (pixel_ctrl.ramp_step) begin
			count <= count + 1'b1;
			if (count == threshold)
				hit <= 1'b1;
		end
	end

	// ramp code follows until the comparator fires, then holds.
	always_ff @(posedge clk) begin
		if (pixel_ctrl.erase)
			code <= '0;
		else if (pixel_ctrl.ramp_step && !hit)
			code <= pixel_ctrl.ramp_code;
	end

endmodule

`default_nettype wire

// ==== pixel_array/pixel_array.sv ====
`default_nettype none

`include "sensor_defines.svh"

module pixel_array (
	input  logic                    clk,
	input  logic                    reset,
	input  sensor_pkg::pixel_ctrl_t pixel_ctrl,
	input  sensor_pkg::row_sel_t    row_sel,
	output sensor_pkg::row_bus_t    row_data
);
	import sensor_pkg::*;

	pixel_code_t codes [`ARRAY_ROWS][`ARRAY_COLS];

	for (genvar r = 0; r < `ARRAY_ROWS; r++) begin : g_row
		for (genvar c = 0; c < `ARRAY_COLS; c++) begin : g_col
			pixel_cell #(
				.row_index(r),
				.col_index(c)
			) cell_i (
				.clk(clk),
				.reset(reset),
				.pixel_ctrl(pixel_ctrl),
				.code(codes[r][c])
			);
		end
	end

	// and-or row mux, all zero when no row is selected.
	always_comb begin
		row_data = '0;
		for (int r = 0; r < `ARRAY_ROWS; r++) begin
			for (int c = 0; c < `ARRAY_COLS; c++)
				row_data[c*`PIXEL_BITS +: `PIXEL_BITS] |= codes[r][c] & {`PIXEL_BITS{row_sel[r]}};
		end
	end

endmodule

`default_nettype wire

// ==== design/row_buffer.sv ====
`default_nettype none

`include "sensor_defines.svh"

module row_buffer (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 new_row,
	input  sensor_pkg::row_bus_t row_data,
	output logic                 out_valid,
	output sensor_pkg::beat_t    out_data
);
	import sensor_pkg::*;

	localparam int beat_bits = $clog2(`BEATS_PER_ROW);
	localparam int beat_width = `BUS_PIXELS * `PIXEL_BITS;

	row_bus_t decoded;
	row_bus_t row_reg; // binary codes of the captured row.
	logic [beat_bits-1:0] beat;

	function automatic pixel_code_t gray_to_bin(input pixel_code_t gray);
		pixel_code_t bin;
		bin[`PIXEL_BITS-1] = gray[`PIXEL_BITS-1];
		for (int i = `PIXEL_BITS - 2; i >= 0; i--)
			bin[i] = bin[i+1] ^ gray[i];
		return bin;
	endfunction

	always_comb begin
		for (int c = 0; c < `ARRAY_COLS; c++)
			decoded[c*`PIXEL_BITS +: `PIXEL_BITS] = gray_to_bin(row_data[c*`PIXEL_BITS +: `PIXEL_BITS]);
	end

	always_ff @(posedge clk) begin
		if (new_row)
			row_reg <= decoded;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			out_valid <= 1'b0;
			beat <= '0;
		end else if (new_row) begin
			out_valid <= 1'b1;
			beat <= '0;
		end else if (out_valid) begin
			if (beat == beat_bits'(`BEATS_PER_ROW - 1))
				out_valid <= 1'b0; // row done, wait for next slot.
			else
				beat <= beat + 1'b1;
		end
	end

	// bus idles at zero between rows.
	assign out_data = out_valid ? row_reg[beat*beat_width +: beat_width] : '0;

	// a row slot must outlast the beats of the previous row.
	no_row_overrun: assert property (@(posedge clk) disable iff (reset) new_row |-> !out_valid);

endmodule

`default_nettype wire

// ==== design/sensor_top.sv ====
`default_nettype none

module sensor_top (
	input  logic              clk,
	input  logic              reset,
	output logic              out_valid,
	output sensor_pkg::beat_t out_data,
	output logic              frame_done
);
	import sensor_pkg::*;

	pixel_ctrl_t pixel_ctrl;
	row_sel_t row_sel;
	logic new_row;
	row_bus_t row_data; // selected row, gray coded.

	frame_sequencer sequencer_i (
		.clk(clk),
		.reset(reset),
		.pixel_ctrl(pixel_ctrl),
		.row_sel(row_sel),
		.new_row(new_row),
		.frame_done(frame_done)
	);

	pixel_array array_i (
		.clk(clk),
		.reset(reset),
		.pixel_ctrl(pixel_ctrl),
		.row_sel(row_sel),
		.row_data(row_data)
	);

	row_buffer buffer_i (
		.clk(clk),
		.reset(reset),
		.new_row(new_row),
		.row_data(row_data),
		.out_valid(out_valid),
		.out_data(out_data)
	);

endmodule

`default_nettype wire

// ==== tests/sensor_tb.sv ====
`default_nettype none

`include "sensor_defines.svh"

module sensor_tb;
	import sensor_pkg::*;

	localparam int beats_per_frame = `ARRAY_ROWS * `BEATS_PER_ROW;
	localparam int frame_cycles = `ERASE_CYCLES + `EXPOSE_CYCLES + `CONVERT_CYCLES
		+ `ARRAY_ROWS * `ROW_CYCLES + 1;
	localparam int frame_limit = frame_cycles + 100; // some slack per frame.

	logic clk = 1'b0;
	logic reset;
	logic out_valid;
	beat_t out_data;
	logic frame_done;

	int mismatch_errors = 0;
	int protocol_errors = 0;
	int timeout_errors = 0;
	int beats_checked = 0;
	int frames_seen = 0;

	// monitor state, cleared by reset.
	int beat_in_frame = 0; // beats seen since the last frame_done.
	int run_len = 0; // consecutive out_valid cycles.
	logic prev_valid = 1'b0;
	logic prev_done = 1'b0;

	sensor_top dut_i (
		.clk(clk),
		.reset(reset),
		.out_valid(out_valid),
		.out_data(out_data),
		.frame_done(frame_done)
	);

	always #4 clk = ~clk;

	// binary pixel value that the array should report for a position.
	function automatic pixel_code_t expected_pixel(input int row, input int col);
		int level;
		level = (row * 29 + col * 11 + 40) % 256;
		return pixel_code_t'(255 - level);
	endfunction

	// outputs are sampled on the falling edge, half a cycle after they change.
	always @(negedge clk) begin : monitor
		int row;
		int col;
		pixel_code_t got_code;
		pixel_code_t exp_code;
		if (reset) begin
			if (out_valid !== 1'b0 || frame_done !== 1'b0 || out_data !== '0) begin
				$display("%0t: outputs not low during reset, out_valid=%b frame_done=%b",
					$time, out_valid, frame_done);
				protocol_errors++;
			end
			beat_in_frame = 0;
			run_len = 0;
			prev_valid = 1'b0;
			prev_done = 1'b0;
		end else begin
			if ($isunknown({out_valid, frame_done})) begin
				$display("%0t: out_valid or frame_done is unknown", $time);
				protocol_errors++;
			end
			if (out_valid === 1'b1 && frame_done === 1'b1) begin
				$display("%0t: a beat appeared in the frame_done cycle", $time);
				protocol_errors++;
			end
			if (out_valid === 1'b1) begin
				if (beat_in_frame >= beats_per_frame) begin
					$display("%0t: more than %0d beats in one frame", $time, beats_per_frame);
					protocol_errors++;
				end else begin
					row = beat_in_frame / `BEATS_PER_ROW;
					for (int n = 0; n < `BUS_PIXELS; n++) begin
						col = (beat_in_frame % `BEATS_PER_ROW) * `BUS_PIXELS + n;
						got_code = out_data[n*`PIXEL_BITS +: `PIXEL_BITS];
						exp_code = expected_pixel(row, col);
						if (got_code !== exp_code) begin
							$display("Mismatch at %0t: out_data (%0d,%0d) got %h expected %h",
								$time, row, col, got_code, exp_code);
							mismatch_errors++;
						end
					end
					beats_checked++;
				end
				beat_in_frame++;
				run_len++;
			end else begin
				// a burst just ended.
				if (prev_valid && run_len != `BEATS_PER_ROW) begin
					$display("%0t: row gave %0d consecutive beats instead of %0d",
						$time, run_len, `BEATS_PER_ROW);
					protocol_errors++;
				end
				run_len = 0;
			end
			if (frame_done === 1'b1) begin
				if (prev_done) begin
					$display("%0t: frame_done held high for more than one cycle", $time);
					protocol_errors++;
				end else begin
					if (beat_in_frame != beats_per_frame) begin
						$display("%0t: frame ended after %0d beats instead of %0d",
							$time, beat_in_frame, beats_per_frame);
						protocol_errors++;
					end
					frames_seen++;
				end
				beat_in_frame = 0;
			end
			prev_valid = (out_valid === 1'b1);
			prev_done = (frame_done === 1'b1);
		end
	end

	// nothing may come out before the first row is read.
	task automatic wait_first_beat(output logic ok);
		int cycles;
		cycles = 0;
		ok = 1'b1;
		while (out_valid !== 1'b1 && cycles < frame_limit) begin
			@(negedge clk);
			cycles++;
			if (frame_done !== 1'b0) begin
				$display("%0t: frame_done is not low before the first beat", $time);
				protocol_errors++;
			end
		end
		if (out_valid !== 1'b1) begin
			$display("%0t: timeout, no beat within %0d cycles after reset", $time, cycles);
			timeout_errors++;
			ok = 1'b0;
		end
	endtask

	task automatic wait_frames(input int n, output logic ok);
		int target;
		int cycles;
		target = frames_seen + n;
		cycles = 0;
		ok = 1'b1;
		while (frames_seen < target && cycles < n * frame_limit) begin
			@(posedge clk);
			cycles++;
		end
		if (frames_seen < target) begin
			$display("%0t: timeout, %0d of %0d frames ended within %0d cycles",
				$time, n - (target - frames_seen), n, cycles);
			timeout_errors++;
			ok = 1'b0;
		end
	endtask

	task automatic finish_run();
		int total;
		if (beats_checked == 0) begin
			$display("no beat was checked in the whole run");
			protocol_errors++;
		end
		total = mismatch_errors + protocol_errors + timeout_errors;
		$display("errors: %0d mismatch, %0d protocol, %0d timeout (%0d beats, %0d frames)",
			mismatch_errors, protocol_errors, timeout_errors, beats_checked, frames_seen);
		if (total == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	endtask

	initial begin : stimulus
		logic ok;
		int reset_at;
		int reset_len;
		void'($urandom(5697));
		reset = 1'b1;
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		wait_first_beat(ok);
		// second frame runs without reset, so only erase clears the cells.
		if (ok)
			wait_frames(2, ok);

		// hit the next frame with a reset somewhere in its middle.
		if (ok) begin
			reset_at = $urandom_range(frame_cycles - 2, 1);
			reset_len = $urandom_range(6, 2);
			$display("%0t: reset after %0d cycles of frame, held %0d cycles",
				$time, reset_at, reset_len);
			repeat (reset_at) @(posedge clk);
			reset <= 1'b1;
			repeat (reset_len) @(posedge clk);
			reset <= 1'b0;
			wait_first_beat(ok);
		end
		if (ok)
			wait_frames(1, ok);

		finish_run();
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+common
common/sensor_pkg.sv
design/frame_sequencer.sv
pixel_array/pixel_cell.sv
pixel_array/pixel_array.sv
design/row_buffer.sv
design/sensor_top.sv
tests/sensor_tb.sv
